//--- rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define RV_RESET_PC 32'h3000_0000
`define RV_ERR_PC   32'h0000_0000 // pc taken after an error response

`define RV_XLEN  32
`define RV_BUS_W 64

// rv32i major opcodes
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_OP     7'b0110011

`endif

//--- rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0]    word_t;
	typedef logic [`RV_BUS_W-1:0]   bus_data_t;
	typedef logic [`RV_BUS_W/8-1:0] strb_t;
	typedef logic [4:0]             reg_idx_t;
	typedef logic [1:0]             resp_t;
	typedef logic [2:0]             size_t; // 0 byte, 1 half, 2 word

	typedef enum logic [2:0] {
		IDLE_FETCH,
		FETCH_WAIT,
		EXEC,
		MEM_REQ,
		MEM_WAIT,
		WRITEBACK
	} ctrl_state_t;

	typedef enum logic [3:0] {
		ALU_R,
		ALU_I,
		LOAD,
		STORE,
		BRANCH,
		JAL,
		JALR,
		LUI,
		AUIPC,
		ILLEGAL
	} inst_class_t;

endpackage

//--- rv_ctrl.sv
`timescale 1ns/1ns

module rv_ctrl import rv_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  inst_class_t inst_class,
	input  logic        fetch_done,
	input  logic        load_done,
	input  logic        store_done,
	input  logic        bus_error,
	output logic        fetch_req,
	output logic        load_req,
	output logic        store_req,
	output logic        inst_load,
	output logic        reg_wen,
	output logic        pc_wen
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic        is_mem;
	logic        writes_rd;

	assign is_mem = (inst_class == LOAD) || (inst_class == STORE);
	assign writes_rd = inst_class inside {ALU_R, ALU_I, LOAD, JAL, JALR, LUI, AUIPC};

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= IDLE_FETCH;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE_FETCH: begin
				state_nxt = FETCH_WAIT; // xbar holds arvalid until accepted
			end
			FETCH_WAIT: begin
				if (fetch_done) begin
					state_nxt = bus_error ? WRITEBACK : EXEC; // bad fetch skips execute
				end
			end
			EXEC: begin
				state_nxt = is_mem ? MEM_REQ : WRITEBACK;
			end
			MEM_REQ: begin
				state_nxt = MEM_WAIT;
			end
			MEM_WAIT: begin
				if (load_done || store_done) begin
					state_nxt = WRITEBACK;
				end
			end
			WRITEBACK: begin
				state_nxt = IDLE_FETCH;
			end
			default: begin
				state_nxt = IDLE_FETCH;
			end
		endcase
	end

	assign fetch_req = (state == IDLE_FETCH);
	assign load_req  = (state == MEM_REQ) && (inst_class == LOAD);
	assign store_req = (state == MEM_REQ) && (inst_class == STORE);
	assign inst_load = (state == FETCH_WAIT) && fetch_done;
	assign pc_wen    = (state == WRITEBACK);
	assign reg_wen   = pc_wen && writes_rd && !bus_error; // no rd update after an error

endmodule

//--- rv_idu.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_idu import rv_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        inst_load,
	input  bus_data_t   rdata,
	input  logic        pc_bit2,
	output inst_class_t inst_class,
	output logic [2:0]  funct3,
	output reg_idx_t    rd,
	output reg_idx_t    rs1,
	output reg_idx_t    rs2,
	output word_t       imm,
	output logic        is_sub
);

	word_t      inst;
	logic [6:0] opcode;
	logic [6:0] funct7;
	logic       alu_f3_ok;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			inst <= '0; // decodes as illegal
		end else if (inst_load) begin
			inst <= pc_bit2 ? rdata[63:32] : rdata[31:0]; // upper word for pc[2]
		end
	end

	assign opcode = inst[6:0];
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign funct7 = inst[31:25];
	assign is_sub = (opcode == `RV_OP_OP) && inst[30];

	assign alu_f3_ok = funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111}; // no shifts, no unsigned

	always_comb begin
		inst_class = ILLEGAL;
		case (opcode)
			`RV_OP_LUI:    inst_class = LUI;
			`RV_OP_AUIPC:  inst_class = AUIPC;
			`RV_OP_JAL:    inst_class = JAL;
			`RV_OP_JALR:   inst_class = (funct3 == 3'b000) ? JALR : ILLEGAL;
			`RV_OP_BRANCH: inst_class = (funct3 inside {3'b000, 3'b001, 3'b100, 3'b101}) ? BRANCH : ILLEGAL;
			`RV_OP_LOAD:   inst_class = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) ? LOAD : ILLEGAL;
			`RV_OP_STORE:  inst_class = (funct3 inside {3'b000, 3'b001, 3'b010}) ? STORE : ILLEGAL;
			`RV_OP_IMM:    inst_class = alu_f3_ok ? ALU_I : ILLEGAL;
			`RV_OP_OP: begin
				if (alu_f3_ok && (funct7 == 7'h00 || (funct7 == 7'h20 && funct3 == 3'b000))) begin
					inst_class = ALU_R;
				end
			end
			default: inst_class = ILLEGAL;
		endcase
	end

	always_comb begin
		case (inst_class)
			STORE:       imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			BRANCH:      imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			LUI, AUIPC:  imm = {inst[31:12], 12'b0};
			JAL:         imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			default:     imm = {{20{inst[31]}}, inst[31:20]}; // i-type
		endcase
	end

endmodule

//--- rv_exu.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_exu import rv_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        pc_wen,
	input  logic        bus_error,
	input  inst_class_t inst_class,
	input  logic [2:0]  funct3,
	input  logic        is_sub,
	input  word_t       src1,
	input  word_t       src2,
	input  word_t       imm,
	output word_t       pc,
	output word_t       alu_result,
	output word_t       mem_addr
);

	word_t pc_plus4;
	word_t op_b;
	word_t alu_out;
	word_t target;
	logic  eq;
	logic  lt;
	logic  cond;
	logic  take;

	assign pc_plus4 = pc + 32'd4;
	assign op_b     = (inst_class == ALU_R || inst_class == BRANCH) ? src2 : imm;
	assign mem_addr = src1 + imm; // also the jalr target
	assign eq       = (src1 == op_b);
	assign lt       = $signed(src1) < $signed(op_b);

	always_comb begin
		case (funct3)
			3'b000:  alu_out = is_sub ? src1 - op_b : src1 + op_b;
			3'b010:  alu_out = {31'b0, lt};
			3'b100:  alu_out = src1 ^ op_b;
			3'b110:  alu_out = src1 | op_b;
			default: alu_out = src1 & op_b;
		endcase
	end

	always_comb begin
		case (inst_class)
			LUI:       alu_result = imm;
			AUIPC:     alu_result = pc + imm;
			JAL, JALR: alu_result = pc_plus4; // link value
			default:   alu_result = alu_out;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000:  cond = eq;
			3'b001:  cond = !eq;
			3'b100:  cond = lt;
			default: cond = !lt; // bge
		endcase
	end

	always_comb begin
		target = pc + imm;
		take   = 1'b0;
		case (inst_class)
			JAL: begin
				take = 1'b1;
			end
			JALR: begin
				take   = 1'b1;
				target = {mem_addr[31:1], 1'b0};
			end
			BRANCH: begin
				take = cond;
			end
			default: begin
				take = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc <= `RV_RESET_PC;
		end else if (pc_wen) begin
			pc <= bus_error ? `RV_ERR_PC : (take ? target : pc_plus4);
		end
	end

endmodule

//--- rv_lsu.sv
`timescale 1ns/1ns

module rv_lsu import rv_pkg::*; (
	input  logic       clock,
	input  logic       rst_n,
	input  word_t      mem_addr,
	input  logic [2:0] funct3,
	input  word_t      src2,
	input  logic       load_done,
	input  bus_data_t  rdata,
	output size_t      arsize,
	output bus_data_t  wdata,
	output strb_t      wstrb,
	output word_t      load_data
);

	logic [2:0] offset;
	strb_t      mask;
	bus_data_t  lane;
	word_t      ext;

	assign offset = mem_addr[2:0]; // byte lane in the 64-bit beat
	assign arsize = {1'b0, funct3[1:0]};

	always_comb begin
		case (funct3[1:0])
			2'b00:   mask = 8'h01;
			2'b01:   mask = 8'h03;
			default: mask = 8'h0f;
		endcase
	end

	// bytes past the top of the beat drop off
	assign wdata = bus_data_t'(src2) << {offset, 3'b000};
	assign wstrb = mask << offset;

	assign lane = rdata >> {offset, 3'b000};

	always_comb begin
		case (funct3)
			3'b000:  ext = {{24{lane[7]}}, lane[7:0]};
			3'b001:  ext = {{16{lane[15]}}, lane[15:0]};
			3'b100:  ext = {24'b0, lane[7:0]};
			3'b101:  ext = {16'b0, lane[15:0]};
			default: ext = lane[31:0]; // lw
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			load_data <= '0;
		end else if (load_done) begin
			load_data <= ext;
		end
	end

endmodule

//--- rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; (
	input  logic     clock,
	input  logic     reg_wen,
	input  reg_idx_t rd,
	input  word_t    wdata,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	output word_t    src1,
	output word_t    src2
);

	word_t regs [0:31];

	always_ff @(posedge clock) begin
		if (reg_wen && (rd != 5'd0)) begin
			regs[rd] <= wdata;
		end
	end

	// x0 reads zero
	assign src1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign src2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- rv_xbar.sv
`timescale 1ns/1ns

module rv_xbar import rv_pkg::*; (
	input  logic  clock,
	input  logic  rst_n,
	input  logic  fetch_req,
	input  logic  load_req,
	input  logic  store_req,
	input  word_t pc,
	input  word_t mem_addr,
	input  size_t lsu_arsize,
	input  logic  arready,
	input  logic  rvalid,
	input  resp_t rresp,
	input  logic  awready,
	input  logic  wready,
	input  logic  bvalid,
	input  resp_t bresp,
	output logic  arvalid,
	output word_t araddr,
	output size_t arsize,
	output logic  awvalid,
	output logic  wvalid,
	output word_t awaddr,
	output logic  fetch_done,
	output logic  load_done,
	output logic  store_done,
	output logic  bus_error
);

	logic owner_load; // read channel owner, 1 for lsu
	logic err_q;
	logic r_err;
	logic b_err;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			arvalid    <= 1'b0;
			awvalid    <= 1'b0;
			wvalid     <= 1'b0;
			owner_load <= 1'b0;
			err_q      <= 1'b0;
		end else begin
			if (fetch_req || load_req) begin
				arvalid    <= 1'b1;
				owner_load <= load_req;
			end else if (arready) begin
				arvalid <= 1'b0;
			end
			// aw and w rise together, each drops on its own ready
			if (store_req) begin
				awvalid <= 1'b1;
				wvalid  <= 1'b1;
			end else begin
				if (awready) begin
					awvalid <= 1'b0;
				end
				if (wready) begin
					wvalid <= 1'b0;
				end
			end
			if (fetch_req) begin
				err_q <= 1'b0; // new instruction
			end else if (r_err || b_err) begin
				err_q <= 1'b1;
			end
		end
	end

	assign r_err = rvalid && (rresp != 2'b00);
	assign b_err = bvalid && (bresp != 2'b00);
	assign bus_error = err_q || r_err || b_err;

	assign araddr = owner_load ? mem_addr : pc;
	assign arsize = owner_load ? lsu_arsize : size_t'(2);
	assign awaddr = mem_addr;

	assign fetch_done = rvalid && !owner_load;
	assign load_done  = rvalid && owner_load;
	assign store_done = bvalid;

endmodule

//--- rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top import rv_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	output logic      arvalid,
	output word_t     araddr,
	output size_t     arsize,
	input  logic      arready,
	input  logic      rvalid,
	input  bus_data_t rdata,
	input  resp_t     rresp,
	output logic      awvalid,
	output word_t     awaddr,
	input  logic      awready,
	output logic      wvalid,
	output bus_data_t wdata,
	output strb_t     wstrb,
	input  logic      wready,
	input  logic      bvalid,
	input  resp_t     bresp
);

	logic        fetch_req;
	logic        load_req;
	logic        store_req;
	logic        inst_load;
	logic        reg_wen;
	logic        pc_wen;
	logic        fetch_done;
	logic        load_done;
	logic        store_done;
	logic        bus_error;
	logic        is_sub;
	inst_class_t inst_class;
	logic [2:0]  funct3;
	reg_idx_t    rd;
	reg_idx_t    rs1;
	reg_idx_t    rs2;
	word_t       imm;
	word_t       src1;
	word_t       src2;
	word_t       pc;
	word_t       alu_result;
	word_t       mem_addr;
	word_t       load_data;
	word_t       wb_data;
	size_t       lsu_arsize;

	assign wb_data = (inst_class == LOAD) ? load_data : alu_result;

	rv_ctrl i_ctrl (
		.clock(clock), .rst_n(rst_n), .inst_class(inst_class),
		.fetch_done(fetch_done), .load_done(load_done), .store_done(store_done),
		.bus_error(bus_error), .fetch_req(fetch_req), .load_req(load_req),
		.store_req(store_req), .inst_load(inst_load), .reg_wen(reg_wen), .pc_wen(pc_wen)
	);

	rv_idu i_idu (
		.clock(clock), .rst_n(rst_n), .inst_load(inst_load), .rdata(rdata),
		.pc_bit2(pc[2]), .inst_class(inst_class), .funct3(funct3), .rd(rd),
		.rs1(rs1), .rs2(rs2), .imm(imm), .is_sub(is_sub)
	);

	rv_exu i_exu (
		.clock(clock), .rst_n(rst_n), .pc_wen(pc_wen), .bus_error(bus_error),
		.inst_class(inst_class), .funct3(funct3), .is_sub(is_sub), .src1(src1),
		.src2(src2), .imm(imm), .pc(pc), .alu_result(alu_result), .mem_addr(mem_addr)
	);

	rv_lsu i_lsu (
		.clock(clock), .rst_n(rst_n), .mem_addr(mem_addr), .funct3(funct3),
		.src2(src2), .load_done(load_done), .rdata(rdata), .arsize(lsu_arsize),
		.wdata(wdata), .wstrb(wstrb), .load_data(load_data)
	);

	rv_regfile i_regfile (
		.clock(clock), .reg_wen(reg_wen), .rd(rd), .wdata(wb_data),
		.rs1(rs1), .rs2(rs2), .src1(src1), .src2(src2)
	);

	rv_xbar i_xbar (
		.clock(clock), .rst_n(rst_n), .fetch_req(fetch_req), .load_req(load_req),
		.store_req(store_req), .pc(pc), .mem_addr(mem_addr), .lsu_arsize(lsu_arsize),
		.arready(arready), .rvalid(rvalid), .rresp(rresp), .awready(awready),
		.wready(wready), .bvalid(bvalid), .bresp(bresp), .arvalid(arvalid),
		.araddr(araddr), .arsize(arsize), .awvalid(awvalid), .wvalid(wvalid),
		.awaddr(awaddr), .fetch_done(fetch_done), .load_done(load_done),
		.store_done(store_done), .bus_error(bus_error)
	);

endmodule

//--- tb_mem.sv
`timescale 1ns/1ns

module tb_mem import rv_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  word_t     err_addr,
	input  bus_data_t img [0:1023],
	input  logic      arvalid,
	input  word_t     araddr,
	input  size_t     arsize,
	output logic      arready,
	output logic      rvalid,
	output bus_data_t rdata,
	output resp_t     rresp,
	input  logic      awvalid,
	input  word_t     awaddr,
	output logic      awready,
	input  logic      wvalid,
	input  bus_data_t wdata,
	input  strb_t     wstrb,
	output logic      wready,
	output logic      bvalid,
	output resp_t     bresp
);

	integer    seed = 26;
	bus_data_t mem [0:1023]; // 64-bit beats, address bits 12 to 3
	logic      rd_pend;
	word_t     rd_addr;
	int        rd_cnt;
	logic      aw_got;
	logic      w_got;
	word_t     wr_addr;
	bus_data_t wr_data;
	strb_t     wr_strb;
	int        wr_cnt;
	int        b;

	word_t     ar_log [$]; // every accepted read address
	size_t     ar_size [$]; // size of each accepted read
	word_t     st_addr [$];
	strb_t     st_strb [$];
	bus_data_t st_data [$];

	always @(posedge clock) begin
		if (!rst_n) begin
			mem     <= img; // image is reloaded during reset
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rdata   <= '0;
			rresp   <= 2'b00;
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			bresp   <= 2'b00;
			rd_pend <= 1'b0;
			rd_addr <= '0;
			rd_cnt  <= 0;
			aw_got  <= 1'b0;
			w_got   <= 1'b0;
			wr_cnt  <= 0;
			ar_log.delete();
			ar_size.delete();
			st_addr.delete();
			st_strb.delete();
			st_data.delete();
		end else begin
			rvalid  <= 1'b0;
			bvalid  <= 1'b0;
			arready <= !rd_pend && !(arvalid && arready) && (($random(seed) & 3) != 0);
			if (arvalid && arready) begin
				rd_pend <= 1'b1;
				rd_addr <= araddr;
				rd_cnt  <= $random(seed) & 3;
				ar_log.push_back(araddr);
				ar_size.push_back(arsize);
			end else if (rd_pend) begin
				if (rd_cnt == 0) begin
					rvalid  <= 1'b1;
					rdata   <= mem[rd_addr[12:3]];
					rresp   <= (rd_addr == err_addr) ? 2'b10 : 2'b00; // slave error
					rd_pend <= 1'b0;
				end else begin
					rd_cnt <= rd_cnt - 1;
				end
			end
			awready <= !aw_got && !(awvalid && awready) && (($random(seed) & 3) != 0);
			wready  <= !w_got && !(wvalid && wready) && (($random(seed) & 3) != 0);
			if (awvalid && awready) begin
				aw_got  <= 1'b1;
				wr_addr <= awaddr;
			end
			if (wvalid && wready) begin
				w_got   <= 1'b1;
				wr_data <= wdata;
				wr_strb <= wstrb;
			end
			if (aw_got && w_got) begin
				if (wr_cnt == 0) begin
					bvalid <= 1'b1;
					bresp  <= (wr_addr == err_addr) ? 2'b10 : 2'b00;
					for (b = 0; b < 8; b++) begin
						if (wr_strb[b]) begin
							mem[wr_addr[12:3]][8*b +: 8] <= wr_data[8*b +: 8];
						end
					end
					st_addr.push_back(wr_addr);
					st_strb.push_back(wr_strb);
					st_data.push_back(wr_data);
					aw_got <= 1'b0;
					w_got  <= 1'b0;
					wr_cnt <= $random(seed) & 3;
				end else begin
					wr_cnt <= wr_cnt - 1;
				end
			end
		end
	end

endmodule

//--- tb_core.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module tb_core import rv_pkg::*; ();

	localparam word_t data_base        = 32'h3000_1000;
	localparam int    max_instr        = 200;
	localparam int    cycles_per_instr = 200;

	logic      clock;
	logic      rst_n;
	word_t     err_addr;
	bus_data_t img [0:1023];
	int        prog_n;
	logic      arvalid;
	word_t     araddr;
	size_t     arsize;
	logic      arready;
	logic      rvalid;
	bus_data_t rdata;
	resp_t     rresp;
	logic      awvalid;
	word_t     awaddr;
	logic      awready;
	logic      wvalid;
	bus_data_t wdata;
	strb_t     wstrb;
	logic      wready;
	logic      bvalid;
	resp_t     bresp;

	rv_core_top i_dut (
		.clock(clock), .rst_n(rst_n), .arvalid(arvalid), .araddr(araddr),
		.arsize(arsize), .arready(arready), .rvalid(rvalid), .rdata(rdata),
		.rresp(rresp), .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
		.wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
		.bvalid(bvalid), .bresp(bresp)
	);

	tb_mem i_mem (
		.clock(clock), .rst_n(rst_n), .err_addr(err_addr), .img(img),
		.arvalid(arvalid), .araddr(araddr), .arsize(arsize), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .awvalid(awvalid),
		.awaddr(awaddr), .awready(awready), .wvalid(wvalid), .wdata(wdata),
		.wstrb(wstrb), .wready(wready), .bvalid(bvalid), .bresp(bresp)
	);

	always #50 clock = ~clock;

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			fail_now($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic compare_strb(input string name, input strb_t exp, input strb_t act);
		if (exp !== act) begin
			fail_now($sformatf("[ERROR] %s strobe: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic compare_addr(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			fail_now($sformatf("[ERROR] %s address: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic compare_size(input string name, input size_t exp, input size_t act);
		if (exp !== act) begin
			fail_now($sformatf("[ERROR] %s size: expected %0d, actual %0d", name, exp, act));
		end
	endtask

	// rv32i encodings
	function automatic word_t enc_i(logic [6:0] op, logic [2:0] f3, reg_idx_t rd,
			reg_idx_t rs1, int imm);
		word_t v;
		v = word_t'(imm);
		return {v[11:0], rs1, f3, rd, op};
	endfunction

	function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
			logic [2:0] f3, reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
	endfunction

	function automatic word_t enc_s(logic [2:0] f3, reg_idx_t rs2, reg_idx_t rs1, int imm);
		word_t v;
		v = word_t'(imm);
		return {v[11:5], rs2, rs1, f3, v[4:0], `RV_OP_STORE};
	endfunction

	function automatic word_t enc_b(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, int imm);
		word_t v;
		v = word_t'(imm);
		return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], `RV_OP_BRANCH};
	endfunction

	function automatic word_t enc_u(logic [6:0] op, reg_idx_t rd, logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic word_t enc_j(reg_idx_t rd, int imm);
		word_t v;
		v = word_t'(imm);
		return {v[20], v[10:1], v[11], v[19:12], rd, `RV_OP_JAL};
	endfunction

	function automatic word_t pc_of(int n);
		return `RV_RESET_PC + word_t'(4 * n);
	endfunction

	function automatic word_t ext_load(bus_data_t beat, int off, int n, bit sgn);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[8*i +: 8] = beat[8*(off+i) +: 8];
		end
		if (sgn && v[8*n-1]) begin
			for (int i = n; i < 4; i++) begin
				v[8*i +: 8] = 8'hff;
			end
		end
		return v;
	endfunction

	function automatic bit branch_taken(logic [2:0] f3, word_t a, word_t b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			default: return !($signed(a) < $signed(b));
		endcase
	endfunction

	task automatic emit(input word_t w);
		img[prog_n/2][(prog_n%2)*32 +: 32] = w;
		prog_n++;
	endtask

	task automatic begin_program(input word_t bad_addr);
		word_t a;
		@(posedge clock);
		rst_n    <= 1'b0;
		err_addr <= bad_addr;
		for (int i = 0; i < 1024; i++) begin
			a = `RV_RESET_PC + word_t'(8 * i);
			img[i] = {~a, a ^ 32'h5a5a_c3c3}; // fill tied to the beat address
		end
		prog_n = 0;
	endtask

	task automatic run_program();
		emit(enc_j(5'd0, 0)); // halt loop
		repeat (10) @(posedge clock);
		rst_n <= 1'b1;
	endtask

	task automatic wait_stores(input int n);
		int c;
		c = 0;
		while (i_mem.st_addr.size() < n) begin
			@(negedge clock);
			c++;
			if (c > prog_n * cycles_per_instr) begin
				fail_now($sformatf("core hung: only %0d of %0d stores seen",
					i_mem.st_addr.size(), n));
			end
		end
	endtask

	task automatic wait_fetches(input int n);
		int c;
		c = 0;
		while (i_mem.ar_log.size() < n) begin
			@(negedge clock);
			c++;
			if (c > prog_n * cycles_per_instr) begin
				fail_now("core hung: read requests stopped");
			end
		end
	endtask

	task automatic check_store(input string name, input int k, input word_t addr,
			input int nbytes, input word_t val);
		logic [2:0] off;
		strb_t      mask;
		word_t      m;
		word_t      act;
		off  = addr[2:0];
		mask = strb_t'((1 << nbytes) - 1) << off;
		m    = (nbytes == 4) ? 32'hffff_ffff : word_t'((1 << (8 * nbytes)) - 1);
		act  = word_t'(i_mem.st_data[k] >> (8 * off)); // lane at the byte offset
		compare_addr(name, addr, i_mem.st_addr[k]);
		compare_strb(name, mask, i_mem.st_strb[k]);
		compare_word(name, val & m, act & m);
	endtask

	task automatic next_fetch(input word_t addr, output word_t nxt);
		int idx;
		idx = -1;
		for (int i = 0; i < i_mem.ar_log.size() - 1; i++) begin
			if (idx < 0 && i_mem.ar_log[i] == addr) begin
				idx = i;
			end
		end
		if (idx < 0) begin
			fail_now($sformatf("no fetch of %h followed by another read", addr));
		end
		nxt = i_mem.ar_log[idx+1];
	endtask

	task automatic test_arith();
		word_t a;
		word_t b;
		word_t exp [0:5];
		a = 32'd100;
		b = -32'sd7;
		exp[0] = a + b;
		exp[1] = a - b;
		exp[2] = a ^ b;
		exp[3] = a | b;
		exp[4] = a & b;
		exp[5] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
		begin_program(32'hffff_fff0);
		emit(enc_u(`RV_OP_LUI, 5'd10, 20'h30001));
		emit(enc_i(`RV_OP_IMM, 3'b000, 5'd1, 5'd0, 100));
		emit(enc_i(`RV_OP_IMM, 3'b000, 5'd2, 5'd0, -7));
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4)); // sub
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd7));
		emit(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd8)); // slt x8, x2, x1
		for (int r = 3; r <= 8; r++) begin
			emit(enc_s(3'b010, reg_idx_t'(r), 5'd10, (r - 3) * 4));
		end
		run_program();
		wait_fetches(1);
		compare_addr("first fetch", `RV_RESET_PC, i_mem.ar_log[0]);
		wait_stores(6);
		for (int k = 0; k < 6; k++) begin
			check_store($sformatf("arith %0d", k), k, data_base + word_t'(4 * k), 4, exp[k]);
		end
	endtask

	task automatic test_loads();
		bus_data_t  beat;
		logic [2:0] f3s [0:4];
		int         sizes [0:4];
		word_t      exp [0:63];
		word_t      exp_addr [0:63];
		size_t      exp_size [0:63];
		int         k;
		int         j;
		beat  = 64'h80f1_7e22_93c4_05a6;
		f3s   = '{3'b000, 3'b100, 3'b001, 3'b101, 3'b010};
		sizes = '{1, 1, 2, 2, 4};
		k = 0;
		begin_program(32'hffff_fff0);
		img[512] = beat; // data_base
		emit(enc_u(`RV_OP_LUI, 5'd10, 20'h30001));
		emit(enc_i(`RV_OP_IMM, 3'b000, 5'd11, 5'd10, 256));
		for (int op = 0; op < 5; op++) begin
			for (int off = 0; off <= 8 - sizes[op]; off++) begin
				emit(enc_i(`RV_OP_LOAD, f3s[op], 5'd5, 5'd10, off));
				emit(enc_s(3'b010, 5'd5, 5'd11, 4 * k));
				exp[k]      = ext_load(beat, off, sizes[op], !f3s[op][2]);
				exp_addr[k] = data_base + word_t'(off);
				exp_size[k] = (sizes[op] == 1) ? 3'd0 : (sizes[op] == 2) ? 3'd1 : 3'd2;
				k++;
			end
		end
		run_program();
		wait_stores(k);
		for (int i = 0; i < k; i++) begin
			check_store($sformatf("load %0d", i), i, data_base + word_t'(256 + 4 * i), 4, exp[i]);
		end
		j = 0;
		for (int i = 0; i < i_mem.ar_log.size(); i++) begin
			if (i_mem.ar_log[i] >= data_base && j < k) begin // data reads only
				compare_addr($sformatf("load %0d", j), exp_addr[j], i_mem.ar_log[i]);
				compare_size($sformatf("load %0d", j), exp_size[j], i_mem.ar_size[i]);
				j++;
			end
		end
		if (j != k) begin
			fail_now($sformatf("only %0d of %0d load reads reached the bus", j, k));
		end
	endtask

	task automatic test_stores();
		int k;
		int n;
		k = 0;
		begin_program(32'hffff_fff0);
		emit(enc_u(`RV_OP_LUI, 5'd10, 20'h30001));
		emit(enc_u(`RV_OP_LUI, 5'd5, 20'h12345));
		emit(enc_i(`RV_OP_IMM, 3'b000, 5'd5, 5'd5, 'h678));
		for (int f = 0; f < 3; f++) begin
			n = 1 << f;
			for (int off = 0; off <= 8 - n; off++) begin
				emit(enc_s(3'(f), 5'd5, 5'd10, off));
			end
		end
		run_program();
		for (int f = 0; f < 3; f++) begin
			n = 1 << f;
			for (int off = 0; off <= 8 - n; off++) begin
				wait_stores(k + 1);
				check_store($sformatf("store size %0d offset %0d", n, off), k,
					data_base + word_t'(off), n, 32'h1234_5678);
				k++;
			end
		end
	endtask

	task automatic test_control();
		logic [2:0] f3s [0:8];
		int         ra [0:8];
		int         rb [0:8];
		word_t      rv [0:2];
		word_t      exp [0:13];
		word_t      pj;
		word_t      pa;
		word_t      pu;
		word_t      nxt;
		f3s = '{3'b000, 3'b000, 3'b001, 3'b001, 3'b100, 3'b100, 3'b101, 3'b101, 3'b101};
		ra  = '{1, 1, 1, 1, 2, 1, 1, 2, 1};
		rb  = '{1, 2, 2, 1, 1, 2, 2, 1, 1};
		rv  = '{32'd0, 32'd5, -32'sd3}; // x0, x1, x2
		begin_program(32'hffff_fff0);
		emit(enc_u(`RV_OP_LUI, 5'd10, 20'h30001));
		emit(enc_i(`RV_OP_IMM, 3'b000, 5'd1, 5'd0, 5));
		emit(enc_i(`RV_OP_IMM, 3'b000, 5'd2, 5'd0, -3));
		for (int c = 0; c < 9; c++) begin
			emit(enc_i(`RV_OP_IMM, 3'b000, 5'd3, 5'd0, 2));
			emit(enc_b(f3s[c], reg_idx_t'(ra[c]), reg_idx_t'(rb[c]), 8));
			emit(enc_i(`RV_OP_IMM, 3'b000, 5'd3, 5'd0, 1)); // fall-through marker
			emit(enc_s(3'b010, 5'd3, 5'd10, 4 * c));
			exp[c] = branch_taken(f3s[c], rv[ra[c]], rv[rb[c]]) ? 32'd2 : 32'd1;
		end
		pj = pc_of(prog_n);
		emit(enc_j(5'd4, 8));
		emit(enc_i(`RV_OP_IMM, 3'b000, 5'd3, 5'd0, 7));
		emit(enc_s(3'b010, 5'd4, 5'd10, 36));
		exp[9] = pj + 32'd4;
		pa = pc_of(prog_n);
		emit(enc_u(`RV_OP_AUIPC, 5'd6, 20'h00000));
		emit(enc_i(`RV_OP_JALR, 3'b000, 5'd7, 5'd6, 16));
		emit(enc_i(`RV_OP_IMM, 3'b000, 5'd3, 5'd0, 7));
		emit(enc_i(`RV_OP_IMM, 3'b000, 5'd3, 5'd0, 7));
		emit(enc_s(3'b010, 5'd7, 5'd10, 40));
		emit(enc_s(3'b010, 5'd6, 5'd10, 44));
		exp[10] = pa + 32'd8;
		exp[11] = pa;
		emit(enc_u(`RV_OP_LUI, 5'd8, 20'habcde));
		emit(enc_s(3'b010, 5'd8, 5'd10, 48));
		exp[12] = 32'habcd_e000;
		pu = pc_of(prog_n);
		emit(enc_u(`RV_OP_AUIPC, 5'd9, 20'h00001));
		emit(enc_s(3'b010, 5'd9, 5'd10, 52));
		exp[13] = pu + 32'h0000_1000;
		run_program();
		wait_stores(14);
		for (int k = 0; k < 14; k++) begin
			check_store($sformatf("control %0d", k), k, data_base + word_t'(4 * k), 4, exp[k]);
		end
		next_fetch(pj, nxt);
		compare_addr("jal target fetch", pj + 32'd8, nxt);
		next_fetch(pa + 32'd4, nxt);
		compare_addr("jalr target fetch", pa + 32'd16, nxt);
	endtask

	task automatic test_error();
		begin_program(data_base + 32'd8);
		emit(enc_u(`RV_OP_LUI, 5'd10, 20'h30001));
		emit(enc_i(`RV_OP_LOAD, 3'b010, 5'd5, 5'd10, 8));
		run_program();
		wait_fetches(4);
		compare_addr("error load", data_base + 32'd8, i_mem.ar_log[2]);
		compare_addr("fetch after error", `RV_ERR_PC, i_mem.ar_log[3]);
	endtask

	initial begin
		#(longint'(max_instr) * cycles_per_instr * 100);
		fail_now("watchdog expired: the core stopped making progress");
	end

	initial begin
		clock    = 1'b0;
		rst_n    = 1'b0;
		err_addr = 32'hffff_fff0;
		prog_n   = 0;
		test_arith();
		test_loads();
		test_stores();
		test_control();
		test_error();
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+.
rv_pkg.sv
rv_ctrl.sv
rv_idu.sv
rv_exu.sv
rv_lsu.sv
rv_regfile.sv
rv_xbar.sv
rv_core_top.sv
tb_mem.sv
tb_core.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove obj_dir"
	@echo "  help   list the targets"

test:
	verilator --binary -f verilog.f --top tb_core -o sim_core
	./obj_dir/sim_core

clean:
	rm -rf obj_dir
